// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module keypad_tb -f build.f -o keypad_sim
	./obj_dir/keypad_sim | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
+incdir+design
design/keypad_pkg.sv
design/keypad_scan.sv
design/key_decode.sv
design/key_debounce.sv
design/key_apb_regs.sv
design/keypad_ctrl_top.sv
tests/tb_clock.sv
tests/keypad_tb.sv

// File: design/key_apb_regs.sv
`default_nettype none
`include "keypad_settings.svh"

module key_apb_regs
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  apb_addr_t   paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        press,
    input  key_code_t   press_code,
    output logic        enable,
    output logic        irq
);

    localparam int DEPTH = `KP_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    key_code_t        fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             irq_en;
    logic             overflow;   // sticky, cleared by writing 1
    logic             access;
    logic             mapped;
    logic             empty;
    logic             pop;
    logic             push;

    assign access = psel && penable;
    assign mapped = (paddr == REG_CTRL) || (paddr == REG_STATUS) || (paddr == REG_DATA);
    assign empty  = (count == '0);
    assign pop    = access && !pwrite && (paddr == REG_DATA) && !empty;
    assign push   = press && ((count != FULL_CNT) || pop);  // a full FIFO drops it

    assign pready  = 1'b1;  // no wait states
    assign pslverr = access && !mapped;
    assign irq     = irq_en && !empty;

    always_comb
    begin
        case (paddr)
            REG_CTRL:   prdata = {30'd0, irq_en, enable};
            REG_STATUS: prdata = 32'(count) | {23'd0, overflow, 8'd0};
            REG_DATA:   prdata = {23'd0, !empty, 4'd0, empty ? 4'h0 : fifo_mem[rd_ptr]};
            default:    prdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            enable   <= 1'b0;
            irq_en   <= 1'b0;
            overflow <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end
        else
        begin
            if (access && pwrite && (paddr == REG_CTRL))
            begin
                enable <= pwdata[0];
                irq_en <= pwdata[1];
            end
            if (access && pwrite && (paddr == REG_STATUS) && pwdata[8])
            begin
                overflow <= 1'b0;
            end
            if (press && !push)
            begin
                overflow <= 1'b1;  // a new drop wins over the clear
            end
            if (push)
            begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_mem[wr_ptr] <= press_code;
        end
    end

    count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= FULL_CNT
    );

endmodule

`default_nettype wire

// File: design/key_debounce.sv
`default_nettype none
`include "keypad_settings.svh"

module key_debounce
    import keypad_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  logic      scan_done,
    input  logic      scan_valid,
    input  key_code_t scan_code,
    output logic      press,
    output key_code_t press_code
);

    localparam int CNT_W = $clog2(`KP_DEBOUNCE_SCANS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`KP_DEBOUNCE_SCANS);

    key_code_t        last_code;
    logic [CNT_W-1:0] stable_cnt;  // equal valid scans so far
    logic [CNT_W-1:0] cnt_next;
    logic             reported;    // press already sent for this hold
    logic             same_code;

    always_comb
    begin
        same_code = scan_valid && (stable_cnt != '0) && (scan_code == last_code);
        if (!scan_valid)
        begin
            cnt_next = '0;  // no key, re-arm
        end
        else if (!same_code)
        begin
            cnt_next = CNT_W'(1);
        end
        else if (stable_cnt == CNT_MAX)
        begin
            cnt_next = CNT_MAX;
        end
        else
        begin
            cnt_next = stable_cnt + 1'b1;
        end
    end

    assign press = enable && scan_done && (cnt_next == CNT_MAX) && !(reported && same_code);
    assign press_code = scan_code;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            stable_cnt <= '0;
            reported   <= 1'b0;
        end
        else if (!enable)
        begin
            stable_cnt <= '0;
            reported   <= 1'b0;
        end
        else if (scan_done)
        begin
            stable_cnt <= cnt_next;
            reported   <= press || (reported && same_code);
        end
    end

    always_ff @(posedge clk)
    begin
        if (scan_done && scan_valid)
        begin
            last_code <= scan_code;
        end
    end

    // the scan before a press already showed the same valid code
    press_after_repeat: assert property (
        @(posedge clk) disable iff (rst)
        press |-> ($past(scan_valid) && ($past(scan_code) == scan_code))
    );

endmodule

`default_nettype wire

// File: design/key_decode.sv
`default_nettype none

module key_decode
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       sample,
    input  col_idx_t   col_idx,
    input  logic [3:0] row,
    output logic       scan_done,
    output key_code_t  scan_code,
    output logic       scan_valid
);

    // indexed by {row, column}
    localparam key_code_t KEY_MAP [16] = '{
        4'h1, 4'h2, 4'h3, 4'hA,
        4'h4, 4'h5, 4'h6, 4'hB,
        4'h7, 4'h8, 4'h9, 4'hC,
        4'h0, 4'hF, 4'hE, 4'hD
    };

    logic [2:0] low_cnt;    // rows low in this sample
    logic [1:0] row_sel;
    logic [1:0] hits;       // saturates at 2, anything above 1 is rollover
    logic [2:0] hits_sum;
    logic [1:0] hits_next;
    key_code_t  code_now;
    key_code_t  code_acc;   // code seen earlier in this scan

    always_comb
    begin
        low_cnt = 3'd0;
        row_sel = 2'd0;
        for (int i = 0; i < 4; i++)
        begin
            if (!row[i])
            begin
                low_cnt = low_cnt + 3'd1;
                row_sel = 2'(3 - i);  // row[3] is the top row
            end
        end
    end

    assign code_now  = KEY_MAP[{row_sel, col_idx}];
    assign hits_sum  = {1'b0, hits} + low_cnt;
    assign hits_next = (hits_sum > 3'd2) ? 2'd2 : hits_sum[1:0];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hits       <= 2'd0;
            scan_done  <= 1'b0;
            scan_valid <= 1'b0;
        end
        else
        begin
            scan_done <= 1'b0;
            if (sample)
            begin
                if (col_idx == 2'd3)
                begin
                    scan_done  <= 1'b1;
                    scan_valid <= (hits_next == 2'd1);
                    hits       <= 2'd0;
                end
                else
                begin
                    hits <= hits_next;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sample && (low_cnt == 3'd1))
        begin
            code_acc <= code_now;
        end
        if (sample && (col_idx == 2'd3))
        begin
            scan_code <= (low_cnt == 3'd1) ? code_now : code_acc;
        end
    end

endmodule

`default_nettype wire

// File: design/keypad_ctrl_top.sv
`default_nettype none

module keypad_ctrl_top
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  apb_addr_t   paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [3:0]  col,
    input  logic [3:0]  row,
    output logic        irq
);

    logic      enable;
    logic      sample;
    col_idx_t  col_idx;
    logic      scan_done;
    key_code_t scan_code;
    logic      scan_valid;
    logic      press;
    key_code_t press_code;

    keypad_scan keypad_scan_i (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .row     (row),
        .col     (col),
        .col_idx (col_idx),
        .sample  (sample)
    );

    key_decode key_decode_i (
        .clk        (clk),
        .rst        (rst),
        .sample     (sample),
        .col_idx    (col_idx),
        .row        (row),
        .scan_done  (scan_done),
        .scan_code  (scan_code),
        .scan_valid (scan_valid)
    );

    key_debounce key_debounce_i (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .scan_done  (scan_done),
        .scan_valid (scan_valid),
        .scan_code  (scan_code),
        .press      (press),
        .press_code (press_code)
    );

    key_apb_regs key_apb_regs_i (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .press      (press),
        .press_code (press_code),
        .enable     (enable),
        .irq        (irq)
    );

endmodule

`default_nettype wire

// File: design/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    // hex value of one key, layout 1 2 3 A / 4 5 6 B / 7 8 9 C / 0 F E D
    typedef logic [3:0] key_code_t;

    // column currently driven low
    typedef logic [1:0] col_idx_t;

    // byte offset inside the register block
    typedef logic [3:0] apb_addr_t;

    localparam apb_addr_t REG_CTRL   = 4'h0;  // enable, irq enable
    localparam apb_addr_t REG_STATUS = 4'h4;  // fifo count, overflow
    localparam apb_addr_t REG_DATA   = 4'h8;  // key code, pops on read

endpackage

`default_nettype wire

// File: design/keypad_scan.sv
`default_nettype none
`include "keypad_settings.svh"

module keypad_scan
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  logic [3:0] row,
    output logic [3:0] col,
    output col_idx_t   col_idx,
    output logic       sample
);

    localparam int TICK_W = $clog2(`KP_SCAN_TICKS);
    localparam logic [TICK_W-1:0] LAST_TICK   = TICK_W'(`KP_SCAN_TICKS - 1);
    localparam logic [TICK_W-1:0] SETTLE_TICK = TICK_W'(`KP_SETTLE_TICKS);

    logic [TICK_W-1:0] tick_cnt;  // position inside the current column

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tick_cnt <= '0;
            col_idx  <= '0;
        end
        else if (!enable)
        begin
            tick_cnt <= '0;  // next scan starts at column 0
            col_idx  <= '0;
        end
        else if (tick_cnt == LAST_TICK)
        begin
            tick_cnt <= '0;
            col_idx  <= col_idx + 2'd1;  // wraps after the fourth column
        end
        else
        begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_comb
    begin
        if (!enable)
        begin
            col = 4'b1111;
        end
        else
        begin
            case (col_idx)
                2'd0:    col = 4'b0111;
                2'd1:    col = 4'b1011;
                2'd2:    col = 4'b1101;
                default: col = 4'b1110;
            endcase
        end
    end

    // rows have settled by now
    assign sample = enable && (tick_cnt == SETTLE_TICK);

    // the driven column only steps on to the next one in scan order
    col_in_order: assert property (
        @(posedge clk) disable iff (rst)
        (enable && $past(enable) && (col != $past(col)))
            |-> (col == {$past(col[0]), $past(col[3:1])})
    );

    // rows float high one cycle after no column is driven
    rows_idle: assert property (
        @(posedge clk) disable iff (rst)
        (col == 4'b1111) |=> (row == 4'b1111)
    );

endmodule

`default_nettype wire

// File: design/keypad_settings.svh
`ifndef KEYPAD_SETTINGS_SVH
`define KEYPAD_SETTINGS_SVH

// cycles each column stays driven low
`define KP_SCAN_TICKS 16
// cycles from a column change to its row sample, below KP_SCAN_TICKS
`define KP_SETTLE_TICKS 4
// equal scans in a row before a press is accepted
`define KP_DEBOUNCE_SCANS 3
// event FIFO entries
`define KP_FIFO_DEPTH 4

`endif

// File: tests/keypad_tb.sv
`default_nettype none
`include "keypad_settings.svh"

module keypad_tb
    import keypad_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCAN_CYCLES = 4 * `KP_SCAN_TICKS;

    typedef struct {
        logic [15:0] keys;       // bit r*4+c is the key in row r, column c
        int          hold;       // scans
        int          gap;        // scans released afterwards
        logic [2:0]  exp_count;
        logic        exp_ovf;
        key_code_t   exp_code;
        logic        read_back;  // pop the entry right after the count check
    } step_t;

    logic        clk;
    logic        rst;
    apb_addr_t   paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [3:0]  col;
    logic [3:0]  row;
    logic        irq;

    logic [15:0] held;
    logic        scan_on = 1'b0;
    step_t       steps[$];
    key_code_t   expect_q[$];
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycles = 0;
    int          limit = 0;

    tb_clock tb_clock_i (
        .clk (clk),
        .rst (rst)
    );

    keypad_ctrl_top keypad_ctrl_top_i (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .col     (col),
        .row     (row),
        .irq     (irq)
    );

    function automatic logic [15:0] key_at(input int r, input int c);
        return 16'(1) << (r * 4 + c);
    endfunction

    // a held key pulls its row low while its column is driven
    function automatic logic [3:0] rows_for(input logic [3:0] col_now, input logic [15:0] keys);
        logic [3:0] rows;
        rows = 4'b1111;
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                if (keys[r * 4 + c] && !col_now[3 - c])
                begin
                    rows[3 - r] = 1'b0;
                end
            end
        end
        return rows;
    endfunction

    function automatic int low_bits(input logic [3:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 4; i++)
        begin
            if (!v[i])
            begin
                n++;
            end
        end
        return n;
    endfunction

    always @(posedge clk)
    begin
        row <= rows_for(col, held);
    end

    always @(negedge clk)
    begin
        if (scan_on && low_bits(col) != 1)
        begin
            other_errors++;
            $display("col at %t does not drive exactly one column low: %b", $time, col);
        end
    end

    task automatic check_code(input string name, input key_code_t got, input key_code_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("Error at %t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("Error at %t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("Error at %t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready)
        begin
            @(negedge clk);
        end
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready)
        begin
            @(negedge clk);
        end
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic read_mapped(input apb_addr_t addr, output logic [31:0] data);
        logic err;
        apb_read(addr, data, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic write_mapped(input apb_addr_t addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic apply_keys(input logic [15:0] keys, input int hold, input int gap);
        @(posedge clk);
        held <= keys;
        repeat (hold * SCAN_CYCLES) @(posedge clk);
        held <= '0;
        repeat (gap * SCAN_CYCLES) @(posedge clk);
    endtask

    task automatic add_step(input logic [15:0] keys, input int hold, input int gap,
                            input logic [2:0] exp_count, input logic exp_ovf,
                            input key_code_t exp_code, input logic read_back);
        step_t st;
        st.keys      = keys;
        st.hold      = hold;
        st.gap       = gap;
        st.exp_count = exp_count;
        st.exp_ovf   = exp_ovf;
        st.exp_code  = exp_code;
        st.read_back = read_back;
        steps.push_back(st);
    endtask

    task automatic build_table();
        // every key once, read back right away
        add_step(key_at(0, 0), 5, 2, 3'd1, 1'b0, 4'h1, 1'b1);
        add_step(key_at(0, 1), 5, 2, 3'd1, 1'b0, 4'h2, 1'b1);
        add_step(key_at(0, 2), 5, 2, 3'd1, 1'b0, 4'h3, 1'b1);
        add_step(key_at(0, 3), 5, 2, 3'd1, 1'b0, 4'hA, 1'b1);
        add_step(key_at(1, 0), 5, 2, 3'd1, 1'b0, 4'h4, 1'b1);
        add_step(key_at(1, 1), 5, 2, 3'd1, 1'b0, 4'h5, 1'b1);
        add_step(key_at(1, 2), 5, 2, 3'd1, 1'b0, 4'h6, 1'b1);
        add_step(key_at(1, 3), 5, 2, 3'd1, 1'b0, 4'hB, 1'b1);
        add_step(key_at(2, 0), 5, 2, 3'd1, 1'b0, 4'h7, 1'b1);
        add_step(key_at(2, 1), 5, 2, 3'd1, 1'b0, 4'h8, 1'b1);
        add_step(key_at(2, 2), 5, 2, 3'd1, 1'b0, 4'h9, 1'b1);
        add_step(key_at(2, 3), 5, 2, 3'd1, 1'b0, 4'hC, 1'b1);
        add_step(key_at(3, 0), 5, 2, 3'd1, 1'b0, 4'h0, 1'b1);
        add_step(key_at(3, 1), 5, 2, 3'd1, 1'b0, 4'hF, 1'b1);
        add_step(key_at(3, 2), 5, 2, 3'd1, 1'b0, 4'hE, 1'b1);
        add_step(key_at(3, 3), 5, 2, 3'd1, 1'b0, 4'hD, 1'b1);
        // too short, then two keys at once
        add_step(key_at(0, 0), 1, 2, 3'd0, 1'b0, 4'h0, 1'b0);
        add_step(key_at(0, 1) | key_at(2, 1), 5, 2, 3'd0, 1'b0, 4'h0, 1'b0);
        add_step(key_at(1, 0) | key_at(3, 2), 5, 2, 3'd0, 1'b0, 4'h0, 1'b0);
        // fill past the FIFO depth
        add_step(key_at(1, 1), 5, 2, 3'd1, 1'b0, 4'h5, 1'b0);
        add_step(key_at(2, 1), 5, 2, 3'd2, 1'b0, 4'h8, 1'b0);
        add_step(key_at(3, 0), 5, 2, 3'd3, 1'b0, 4'h0, 1'b0);
        add_step(key_at(3, 3), 5, 2, 3'd4, 1'b0, 4'hD, 1'b0);
        add_step(key_at(2, 0), 5, 2, 3'd4, 1'b1, 4'h7, 1'b0);
        add_step(key_at(1, 3), 5, 2, 3'd4, 1'b1, 4'hB, 1'b0);
    endtask

    initial
    begin
        wait (limit > 0);
        while (cycles < limit)
        begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        other_errors++;
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        logic [31:0] data;
        logic        err;
        logic        irq_on;
        logic [2:0]  prev_count;
        key_code_t   exp_code;
        int          total_scans;
        step_t       st;

        $timeformat(-9, 1, " ns", 10);
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        row     = 4'b1111;
        held    = '0;
        build_table();
        total_scans = 0;
        foreach (steps[i])
        begin
            total_scans += steps[i].hold + steps[i].gap;
        end
        limit = total_scans * SCAN_CYCLES + 40 * steps.size() + 1000;  // margin for APB

        wait (rst === 1'b0);
        @(negedge clk);
        check_flag("col idle", col == 4'b1111, 1'b1);
        check_flag("irq", irq, 1'b0);
        read_mapped(REG_STATUS, data);
        check_count("fifo count", data[2:0], 3'd0);
        check_flag("overflow", data[8], 1'b0);
        read_mapped(REG_CTRL, data);
        check_flag("enable", data[0], 1'b0);

        write_mapped(REG_CTRL, 32'h1);
        scan_on    = 1'b1;
        irq_on     = 1'b0;
        prev_count = 3'd0;

        foreach (steps[i])
        begin
            st = steps[i];
            apply_keys(st.keys, st.hold, st.gap);
            read_mapped(REG_STATUS, data);
            check_count("fifo count", data[2:0], st.exp_count);
            check_flag("overflow", data[8], st.exp_ovf);
            @(negedge clk);
            check_flag("irq", irq, irq_on && (st.exp_count != 3'd0));
            if (st.read_back)
            begin
                read_mapped(REG_DATA, data);
                check_code("key code", data[3:0], st.exp_code);
                check_flag("data valid", data[8], 1'b1);
                prev_count = st.exp_count - 3'd1;
            end
            else
            begin
                if (st.exp_count > prev_count)
                begin
                    expect_q.push_back(st.exp_code);  // accepted into the FIFO
                end
                prev_count = st.exp_count;
            end
        end

        write_mapped(REG_CTRL, 32'h3);
        irq_on = 1'b1;
        @(negedge clk);
        check_flag("irq", irq, 1'b1);
        while (expect_q.size() > 0)
        begin
            exp_code = expect_q.pop_front();
            read_mapped(REG_DATA, data);
            check_code("drained code", data[3:0], exp_code);
            check_flag("data valid", data[8], 1'b1);
        end
        @(negedge clk);
        check_flag("irq", irq, 1'b0);

        read_mapped(REG_STATUS, data);
        check_count("fifo count", data[2:0], 3'd0);
        check_flag("overflow", data[8], 1'b1);
        write_mapped(REG_STATUS, 32'h100);
        read_mapped(REG_STATUS, data);
        check_flag("overflow", data[8], 1'b0);
        read_mapped(REG_DATA, data);
        check_flag("data valid", data[8], 1'b0);  // nothing left

        apb_read(4'hC, data, err);
        check_flag("pslverr", err, 1'b1);
        apb_write(4'hC, 32'h0, err);
        check_flag("pslverr", err, 1'b1);

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire
